// File: hdl/tag_store_consts.svh
//--------------------------------------------------------------------------
// Size constants of the cache tag store.
// Included by the type packages and by any module that sizes arrays,
// loops or delay lines from them.
//--------------------------------------------------------------------------
`ifndef TAG_STORE_CONSTS_SVH
`define TAG_STORE_CONSTS_SVH

// Associativity, one tag RAM per way
`define TS_WAYS 4
// Set index width, 16 sets
`define TS_INDEX_W 4
// Width of a stored tag
`define TS_TAG_W 8
// Cycles from a RAM read to its data
`define TS_RAM_LAT 1

`endif

// File: hdl/tag_entry_pkg.sv
//--------------------------------------------------------------------------
// Types for what the tag store keeps per way and set.
// A tag_entry_t is exactly one word of a way RAM.
//--------------------------------------------------------------------------
`include "tag_store_consts.svh"

package tag_entry_pkg;

  typedef logic [`TS_TAG_W-1:0]   tag_t;
  typedef logic [`TS_INDEX_W-1:0] index_t;
  // One bit per way, used as mask or as one-hot way
  typedef logic [`TS_WAYS-1:0]    way_ind_t;

  // One RAM word
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

endpackage

// File: hdl/tag_access_pkg.sv
//--------------------------------------------------------------------------
// Types for requests to and responses from the tag store, and the write
// port bundle that control drives to the way RAMs.
//--------------------------------------------------------------------------
package tag_access_pkg;
  import tag_entry_pkg::*;

  typedef enum logic {
    TAG_LOOKUP = 1'b0,
    TAG_FLUSH  = 1'b1
  } tag_mode_e;

  typedef struct packed {
    tag_mode_e mode;
    // Allowed ways on lookup, the one way on flush
    way_ind_t  mask;
    index_t    index;
    tag_t      tag;
    logic      dirty;
  } tag_req_t;

  typedef struct packed {
    way_ind_t way;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

  typedef struct packed {
    way_ind_t   mask;
    index_t     index;
    tag_entry_t entry;
  } ram_wr_t;

endpackage

// File: hdl/tag_way_ram.sv
//--------------------------------------------------------------------------
// Tag memory of one way, built from flops and cleared by reset.
// A read returns its entry TS_RAM_LAT cycles later with a valid pulse;
// the read data then holds until the next read, like an SRAM output.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tag_way_ram
  import tag_entry_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       rd_i,
  input  logic       we_i,
  input  index_t     index_i,
  input  tag_entry_t wdata_i,
  output tag_entry_t rdata_o,
  output logic       rvalid_o
);

  localparam int unsigned Lat = `TS_RAM_LAT;

  tag_entry_t           mem [2**`TS_INDEX_W];
  logic       [Lat-1:0] rv_q;
  tag_entry_t           data_q [Lat];

  // Storage, all entries invalid after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem <= '{default: '0};
    end else if (we_i) begin
      mem[index_i] <= wdata_i;
    end
  end

  // Read valid token travels down the delay line
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rv_q <= '0;
    end else begin
      rv_q[0] <= rd_i;
      for (int k = 1; k < Lat; k++) begin
        rv_q[k] <= rv_q[k-1];
      end
    end
  end

  // Data stages only move with their token, so the last one holds
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      data_q[0] <= mem[index_i];
    end
    for (int k = 1; k < Lat; k++) begin
      if (rv_q[k-1]) begin
        data_q[k] <= data_q[k-1];
      end
    end
  end

  assign rdata_o  = data_q[Lat-1];
  assign rvalid_o = rv_q[Lat-1];

  // Single port, control never mixes a read and a write
  a_no_rd_wr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rd_i && we_i));

endmodule

// File: hdl/tag_hit_detect.sv
//--------------------------------------------------------------------------
// Hit detection over the read entries of all ways.
// Also muxes out the stored entry of one selected way, which is the hit
// way or the victim on lookup and the given way on flush.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tag_hit_detect
  import tag_entry_pkg::*;
(
  input  tag_entry_t [`TS_WAYS-1:0] entries_i,
  input  tag_t                      tag_i,
  input  way_ind_t                  mask_i,
  input  way_ind_t                  sel_way_i,
  output way_ind_t                  valid_o,
  output way_ind_t                  dirty_o,
  output way_ind_t                  hit_o,
  output tag_entry_t                sel_entry_o
);

  localparam int unsigned IdxW = (`TS_WAYS > 1) ? $clog2(`TS_WAYS) : 1;

  logic [IdxW-1:0] sel_idx;

  for (genvar i = 0; i < `TS_WAYS; i++) begin : gen_way
    assign valid_o[i] = entries_i[i].valid;
    assign dirty_o[i] = entries_i[i].dirty;
    // Only allowed, valid ways with an equal tag hit
    assign hit_o[i]   = mask_i[i] & entries_i[i].valid & (entries_i[i].tag == tag_i);
  end

  // One-hot to binary, OR of the set bit positions
  always_comb begin
    sel_idx = '0;
    for (int i = 0; i < `TS_WAYS; i++) begin
      if (sel_way_i[i]) begin
        sel_idx |= IdxW'(i);
      end
    end
  end

  assign sel_entry_o = entries_i[sel_idx];

endmodule

// File: hdl/victim_select.sv
//--------------------------------------------------------------------------
// Victim way choice for a lookup miss.
// Takes the lowest free unlocked way; with no free way it steps round-robin
// from its pointer past locked ways. Result is registered, one cycle after
// the request, and holds until the next request.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module victim_select
  import tag_entry_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  way_ind_t valid_i,
  input  way_ind_t dirty_i,
  input  way_ind_t lock_i,
  output way_ind_t way_o,
  output logic     evict_o,
  output logic     valid_o
);

  localparam int unsigned IdxW = (`TS_WAYS > 1) ? $clog2(`TS_WAYS) : 1;

  way_ind_t        free;
  logic            use_rr;
  logic            found;
  logic [IdxW-1:0] cand;
  logic [IdxW-1:0] pick;
  logic [IdxW-1:0] rr_q;

  assign free   = ~valid_i & ~lock_i;
  assign use_rr = ~|free;

  always_comb begin
    pick  = '0;
    found = 1'b0;
    cand  = '0;
    if (!use_rr) begin
      // Lowest numbered free way
      for (int i = 0; i < `TS_WAYS; i++) begin
        if (!found && free[i]) begin
          pick  = IdxW'(i);
          found = 1'b1;
        end
      end
    end else begin
      // Walk forward from the pointer, skipping locked ways
      for (int k = 0; k < `TS_WAYS; k++) begin
        cand = rr_q + IdxW'(k);
        if (!found && !lock_i[cand]) begin
          pick  = cand;
          found = 1'b1;
        end
      end
    end
  end

  // Control state, pointer starts at way 0
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q    <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i;
      if (req_i && use_rr) begin
        rr_q <= pick + 1'b1;
      end
    end
  end

  // Result payload
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      way_o   <= way_ind_t'(1) << pick;
      evict_o <= valid_i[pick] & dirty_i[pick];
    end
  end

  a_not_all_locked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> !(&lock_i));

endmodule

// File: hdl/tag_store_ctrl.sv
//--------------------------------------------------------------------------
// Control of the tag store: idle/busy flag, request register, read valid
// latch, response forming and the RAM write on response acceptance.
// One request is in flight at a time; ready_o is high only while idle.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tag_store_ctrl
  import tag_entry_pkg::*;
  import tag_access_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  tag_req_t   req_i,
  input  logic       valid_i,
  output logic       ready_o,
  output logic       ram_rd_o,
  output way_ind_t   ram_rd_mask_o,
  output index_t     ram_rd_index_o,
  output ram_wr_t    ram_wr_o,
  input  way_ind_t   rvalid_i,
  input  way_ind_t   hit_i,
  input  tag_entry_t sel_entry_i,
  output way_ind_t   sel_way_o,
  output tag_t       req_tag_o,
  output way_ind_t   req_mask_o,
  output logic       evict_req_o,
  input  way_ind_t   victim_i,
  input  logic       victim_evict_i,
  input  logic       victim_valid_i,
  output tag_res_t   res_o,
  output logic       res_valid_o,
  input  logic       res_ready_i
);

  logic     busy_q;
  tag_req_t req_q;
  logic     rvalid_q;
  logic     evict_sent_q;
  logic     vic_seen_q;
  logic     accept;
  logic     rdata_ok;
  logic     hit_any;
  logic     is_lookup;
  logic     res_fire;

  // ------------------------------------------------------------------------
  // Request side, read issued in the acceptance cycle
  // ------------------------------------------------------------------------
  assign ready_o        = ~busy_q;
  assign accept         = valid_i & ~busy_q;
  assign ram_rd_o       = accept;
  assign ram_rd_mask_o  = req_i.mask;
  assign ram_rd_index_o = req_i.index;

  assign req_tag_o  = req_q.tag;
  assign req_mask_o = req_q.mask;

  // Read data present now or seen earlier
  assign rdata_ok  = busy_q & ((|rvalid_i) | rvalid_q);
  assign hit_any   = |hit_i;
  assign is_lookup = (req_q.mode == TAG_LOOKUP);
  assign res_fire  = res_valid_o & res_ready_i;

  // Entry to report or update: given way, hit way or victim
  assign sel_way_o = !is_lookup ? req_q.mask : (hit_any ? hit_i : victim_i);

  // Single pulse per miss
  assign evict_req_o = rdata_ok & is_lookup & ~hit_any & ~evict_sent_q;

  // ------------------------------------------------------------------------
  // Response forming
  // ------------------------------------------------------------------------
  always_comb begin
    res_valid_o = 1'b0;
    res_o       = '0;
    if (rdata_ok) begin
      if (!is_lookup) begin
        res_valid_o     = 1'b1;
        res_o.way       = req_q.mask;
        res_o.evict     = sel_entry_i.valid & sel_entry_i.dirty;
        res_o.evict_tag = sel_entry_i.tag;
      end else if (hit_any) begin
        res_valid_o = 1'b1;
        res_o.way   = hit_i;
        res_o.hit   = 1'b1;
      end else begin
        // Miss waits for the victim
        res_valid_o     = victim_valid_i | vic_seen_q;
        res_o.way       = victim_i;
        res_o.evict     = victim_evict_i;
        res_o.evict_tag = sel_entry_i.tag;
      end
    end
  end

  // RAM update in the cycle the response is taken
  always_comb begin
    ram_wr_o = '0;
    if (res_fire) begin
      ram_wr_o.index = req_q.index;
      if (!is_lookup) begin
        // Flush leaves an all zero entry
        ram_wr_o.mask = req_q.mask;
      end else if (!hit_any) begin
        ram_wr_o.mask  = victim_i;
        ram_wr_o.entry = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
      end else if (req_q.dirty && !sel_entry_i.dirty) begin
        ram_wr_o.mask  = hit_i;
        ram_wr_o.entry = '{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
      end
    end
  end

  // ------------------------------------------------------------------------
  // State
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      rvalid_q     <= 1'b0;
      evict_sent_q <= 1'b0;
      vic_seen_q   <= 1'b0;
    end else if (res_fire) begin
      // Back to idle, ready again next cycle
      busy_q       <= 1'b0;
      rvalid_q     <= 1'b0;
      evict_sent_q <= 1'b0;
      vic_seen_q   <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end
      if (|rvalid_i) begin
        rvalid_q <= 1'b1;
      end
      if (evict_req_o) begin
        evict_sent_q <= 1'b1;
      end
      if (victim_valid_i) begin
        vic_seen_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rdata_ok |-> $onehot0(hit_i));

  a_res_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)));

endmodule

// File: hdl/result_spill.sv
//--------------------------------------------------------------------------
// Two-entry spill register on the response path.
// Cuts the path from the consumer's ready back into control and keeps
// responses in order. Slot a drives the output, slot b catches overflow.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module result_spill
  import tag_access_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  tag_res_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output tag_res_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  logic     a_full_q;
  logic     b_full_q;
  tag_res_t a_data_q;
  tag_res_t b_data_q;
  logic     in_fire;
  logic     out_fire;

  assign ready_o  = ~b_full_q;
  assign valid_o  = a_full_q;
  assign data_o   = a_data_q;
  assign in_fire  = valid_i & ~b_full_q;
  assign out_fire = a_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (out_fire) begin
      // b moves up, or the new entry goes straight to a
      a_full_q <= b_full_q | in_fire;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_full_q | in_fire;
      b_full_q <= b_full_q | (in_fire & a_full_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_fire) begin
      a_data_q <= b_full_q ? b_data_q : data_i;
    end else if (in_fire && !a_full_q) begin
      a_data_q <= data_i;
    end
    if (in_fire && a_full_q && !out_fire) begin
      b_data_q <= data_i;
    end
  end

endmodule

// File: hdl/tag_store.sv
//--------------------------------------------------------------------------
// Tag store of a set-associative last-level cache.
// Lookup reports hit or victim and installs the tag; flush reports and
// clears one way. Requests and responses use valid/ready handshakes.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tag_store
  import tag_entry_pkg::*;
  import tag_access_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  way_ind_t spm_lock_i,
  input  tag_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output tag_res_t res_o,
  output logic     valid_o,
  input  logic     ready_i
);

  // RAM ports
  logic                      ram_rd;
  way_ind_t                  ram_rd_mask;
  index_t                    ram_rd_index;
  ram_wr_t                   ram_wr;
  tag_entry_t [`TS_WAYS-1:0] ram_rdata;
  way_ind_t                  ram_rvalid;
  // Hit detection and victim
  way_ind_t                  tag_valid;
  way_ind_t                  tag_dirty;
  way_ind_t                  hit;
  way_ind_t                  sel_way;
  tag_entry_t                sel_entry;
  tag_t                      req_tag;
  way_ind_t                  req_mask;
  logic                      evict_req;
  way_ind_t                  victim;
  logic                      victim_evict;
  logic                      victim_valid;
  // Response into the spill register
  tag_res_t                  res;
  logic                      res_valid;
  logic                      res_ready;

  tag_store_ctrl i_ctrl (
    .clk_i, .rst_n_i, .req_i, .valid_i, .ready_o,
    .ram_rd_o       (ram_rd),
    .ram_rd_mask_o  (ram_rd_mask),
    .ram_rd_index_o (ram_rd_index),
    .ram_wr_o       (ram_wr),
    .rvalid_i       (ram_rvalid),
    .hit_i          (hit),
    .sel_entry_i    (sel_entry),
    .sel_way_o      (sel_way),
    .req_tag_o      (req_tag),
    .req_mask_o     (req_mask),
    .evict_req_o    (evict_req),
    .victim_i       (victim),
    .victim_evict_i (victim_evict),
    .victim_valid_i (victim_valid),
    .res_o          (res),
    .res_valid_o    (res_valid),
    .res_ready_i    (res_ready)
  );

  for (genvar i = 0; i < `TS_WAYS; i++) begin : gen_way_ram
    tag_way_ram i_ram (
      .clk_i, .rst_n_i,
      .rd_i     (ram_rd & ram_rd_mask[i]),
      .we_i     (ram_wr.mask[i]),
      .index_i  (ram_rd ? ram_rd_index : ram_wr.index),
      .wdata_i  (ram_wr.entry),
      .rdata_o  (ram_rdata[i]),
      .rvalid_o (ram_rvalid[i])
    );
  end

  tag_hit_detect i_hit_detect (
    .entries_i   (ram_rdata),
    .tag_i       (req_tag),
    .mask_i      (req_mask),
    .sel_way_i   (sel_way),
    .valid_o     (tag_valid),
    .dirty_o     (tag_dirty),
    .hit_o       (hit),
    .sel_entry_o (sel_entry)
  );

  victim_select i_victim (
    .clk_i, .rst_n_i,
    .req_i   (evict_req),
    .valid_i (tag_valid),
    .dirty_i (tag_dirty),
    .lock_i  (spm_lock_i),
    .way_o   (victim),
    .evict_o (victim_evict),
    .valid_o (victim_valid)
  );

  result_spill i_spill (
    .clk_i, .rst_n_i,
    .data_i  (res),
    .valid_i (res_valid),
    .ready_o (res_ready),
    .data_o  (res_o),
    .valid_o,
    .ready_i
  );

endmodule

// File: verif/tag_store_tb.sv
//--------------------------------------------------------------------------
// Directed testbench for the cache tag store.
// Keeps a reference model of all tag entries and the round-robin pointer,
// sends one request per operation and compares the response with the
// model. Random tags, indices and ready gaps come from a Galois LFSR.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "tag_store_consts.svh"

module tag_store_tb
  import tag_entry_pkg::*;
  import tag_access_pkg::*;
();

  localparam int          half_period = 10;
  localparam int          drive_dly   = 1;
  localparam int unsigned n_sets      = 2**`TS_INDEX_W;
  localparam int unsigned ready_limit = 50;
  localparam int unsigned resp_limit  = 200;
  localparam logic [31:0] lfsr_seed   = 32'hcb46_e36d;

  logic     clk;
  logic     rst_n;
  way_ind_t spm_lock;
  tag_req_t req;
  logic     req_valid;
  logic     req_ready;
  tag_res_t res;
  logic     res_valid;
  logic     res_ready;

  // Reference model state
  tag_entry_t  model [n_sets][`TS_WAYS];
  int unsigned rr_ptr;
  logic [31:0] lfsr_state;
  logic        ready_gaps;

  tag_store i_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .spm_lock_i (spm_lock),
    .req_i      (req),
    .valid_i    (req_valid),
    .ready_o    (req_ready),
    .res_o      (res),
    .valid_o    (res_valid),
    .ready_i    (res_ready)
  );

  initial clk = 1'b0;
  always #(half_period) clk = ~clk;

  // --------------------------------------------------------------------------
  // Random numbers and checking
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped after the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  function automatic int way_number(input way_ind_t onehot);
    int num;
    num = 0;
    for (int w = 0; w < `TS_WAYS; w++) begin
      if (onehot[w]) begin
        num = w;
      end
    end
    return num;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  task automatic predict_lookup(input index_t idx, input tag_t tag, input logic dirty,
                                input way_ind_t lock, output tag_res_t exp);
    int   hit_way;
    int   pick;
    int   cand;
    logic found;
    hit_way = -1;
    pick    = 0;
    found   = 1'b0;
    exp     = '0;
    for (int w = 0; w < `TS_WAYS; w++) begin
      if (model[idx][w].valid && model[idx][w].tag == tag) begin
        hit_way = w;
      end
    end
    if (hit_way >= 0) begin
      // Hit only ever sets the dirty bit
      exp.way = way_ind_t'(1) << hit_way;
      exp.hit = 1'b1;
      if (dirty) begin
        model[idx][hit_way].dirty = 1'b1;
      end
    end else begin
      // Lowest free unlocked way first
      for (int w = 0; w < `TS_WAYS; w++) begin
        if (!found && !model[idx][w].valid && !lock[w]) begin
          pick  = w;
          found = 1'b1;
        end
      end
      // Set full, round-robin past locked ways
      if (!found) begin
        for (int k = 0; k < `TS_WAYS; k++) begin
          cand = (int'(rr_ptr) + k) % `TS_WAYS;
          if (!found && !lock[cand]) begin
            pick  = cand;
            found = 1'b1;
          end
        end
        rr_ptr = (pick + 1) % `TS_WAYS;
      end
      exp.way       = way_ind_t'(1) << pick;
      exp.evict     = model[idx][pick].valid & model[idx][pick].dirty;
      exp.evict_tag = model[idx][pick].tag;
      model[idx][pick].valid = 1'b1;
      model[idx][pick].dirty = dirty;
      model[idx][pick].tag   = tag;
    end
  endtask

  task automatic predict_flush(input index_t idx, input int way, output tag_res_t exp);
    exp           = '0;
    exp.way       = way_ind_t'(1) << way;
    exp.evict     = model[idx][way].valid & model[idx][way].dirty;
    exp.evict_tag = model[idx][way].tag;
    model[idx][way] = '0;
  endtask

  // Tag not present in the set, so a lookup of it misses
  task automatic fresh_tag(input index_t idx, output tag_t tag);
    logic [31:0] bits;
    logic        clash;
    tag   = '0;
    clash = 1'b1;
    for (int tries = 0; tries < 64 && clash; tries++) begin
      take_bits(`TS_TAG_W, bits);
      tag   = bits[`TS_TAG_W-1:0];
      clash = 1'b0;
      for (int w = 0; w < `TS_WAYS; w++) begin
        if (model[idx][w].valid && model[idx][w].tag == tag) begin
          clash = 1'b1;
        end
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Handshakes, all driven drive_dly after a rising edge
  // --------------------------------------------------------------------------
  task automatic send_request(input tag_req_t r);
    int unsigned cycles;
    logic        taken;
    cycles    = 0;
    taken     = 1'b0;
    req       = r;
    req_valid = 1'b1;
    while (!taken) begin
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #(drive_dly);
      cycles++;
      if (!taken && cycles > ready_limit) begin
        $display("Timeout: ready_o stayed low for %0d cycles", ready_limit);
        stop_run();
      end
    end
    req_valid = 1'b0;
    req       = '0;
  endtask

  task automatic get_response(output tag_res_t r);
    int unsigned cycles;
    logic        done;
    logic        seen;
    tag_res_t    held;
    logic [31:0] gap;
    cycles = 0;
    done   = 1'b0;
    seen   = 1'b0;
    held   = '0;
    r      = '0;
    while (!done) begin
      @(negedge clk);
      if (seen && !res_valid) begin
        $display("valid_o dropped at %0t ns before the response was taken", $time);
        stop_run();
      end
      if (res_valid) begin
        // Offered response must hold until taken
        if (seen) begin
          check_value("res_o while held", 32'(res), 32'(held));
        end
        seen = 1'b1;
        held = res;
        if (res_ready) begin
          r    = res;
          done = 1'b1;
        end
      end
      @(posedge clk);
      #(drive_dly);
      if (ready_gaps) begin
        take_bits(2, gap);
        res_ready = (gap[1:0] != 2'b00);
      end else begin
        res_ready = 1'b1;
      end
      cycles++;
      if (!done && cycles > resp_limit) begin
        $display("Timeout: no response taken within %0d cycles", resp_limit);
        stop_run();
      end
    end
  endtask

  task automatic compare_result(input tag_res_t got, input tag_res_t exp);
    check_value("res_o.way", 32'(got.way), 32'(exp.way));
    check_value("res_o.hit", 32'(got.hit), 32'(exp.hit));
    check_value("res_o.evict", 32'(got.evict), 32'(exp.evict));
    check_value("res_o.evict_tag", 32'(got.evict_tag), 32'(exp.evict_tag));
  endtask

  task automatic do_lookup(input index_t idx, input tag_t tag, input logic dirty,
                           output tag_res_t got);
    tag_req_t r;
    tag_res_t exp;
    r       = '0;
    r.mode  = TAG_LOOKUP;
    r.mask  = '1;
    r.index = idx;
    r.tag   = tag;
    r.dirty = dirty;
    predict_lookup(idx, tag, dirty, spm_lock, exp);
    send_request(r);
    get_response(got);
    compare_result(got, exp);
  endtask

  task automatic do_flush(input index_t idx, input int way, output tag_res_t got);
    tag_req_t r;
    tag_res_t exp;
    r       = '0;
    r.mode  = TAG_FLUSH;
    r.mask  = way_ind_t'(1) << way;
    r.index = idx;
    predict_flush(idx, way, exp);
    send_request(r);
    get_response(got);
    compare_result(got, exp);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_miss_then_hit();
    tag_t     tag;
    tag_res_t got;
    fresh_tag(4'd1, tag);
    // Empty set, nothing locked, so way 0 and no eviction
    do_lookup(4'd1, tag, 1'b0, got);
    check_value("res_o.hit", 32'(got.hit), 32'd0);
    check_value("res_o.way", 32'(got.way), 32'h1);
    check_value("res_o.evict", 32'(got.evict), 32'd0);
    do_lookup(4'd1, tag, 1'b0, got);
    check_value("res_o.hit", 32'(got.hit), 32'd1);
    check_value("res_o.way", 32'(got.way), 32'h1);
  endtask

  task automatic test_dirty_hit_flush();
    tag_t     tag;
    tag_res_t got;
    fresh_tag(4'd2, tag);
    do_lookup(4'd2, tag, 1'b0, got);
    do_lookup(4'd2, tag, 1'b1, got);
    check_value("res_o.hit", 32'(got.hit), 32'd1);
    // Line is dirty now and must come out on flush
    do_flush(4'd2, way_number(got.way), got);
    check_value("res_o.evict", 32'(got.evict), 32'd1);
    check_value("res_o.evict_tag", 32'(got.evict_tag), 32'(tag));
  endtask

  task automatic test_round_robin();
    tag_t        tag;
    tag_res_t    got;
    logic [31:0] bits;
    // Four fills, then six replacements
    for (int n = 0; n < 10; n++) begin
      fresh_tag(4'd3, tag);
      take_bits(1, bits);
      do_lookup(4'd3, tag, bits[0], got);
      check_value("res_o.hit", 32'(got.hit), 32'd0);
    end
  endtask

  task automatic test_locked_ways();
    tag_t        tag;
    tag_res_t    got;
    logic [31:0] bits;
    spm_lock = 4'b0101;
    for (int n = 0; n < 6; n++) begin
      fresh_tag(4'd4, tag);
      take_bits(1, bits);
      do_lookup(4'd4, tag, bits[0], got);
      check_value("res_o.way & spm_lock_i", 32'(got.way & spm_lock), 32'd0);
    end
    spm_lock = '0;
  endtask

  task automatic test_flush_clears();
    tag_t     tag;
    tag_res_t got;
    fresh_tag(4'd5, tag);
    do_lookup(4'd5, tag, 1'b1, got);
    do_flush(4'd5, way_number(got.way), got);
    do_lookup(4'd5, tag, 1'b0, got);
    check_value("res_o.hit", 32'(got.hit), 32'd0);
  endtask

  task automatic test_random_traffic();
    logic [31:0] bits;
    index_t      idx;
    tag_t        tag;
    tag_res_t    got;
    int          way;
    ready_gaps = 1'b1;
    for (int n = 0; n < 40; n++) begin
      take_bits(`TS_INDEX_W, bits);
      idx = bits[`TS_INDEX_W-1:0];
      take_bits(2, bits);
      way = int'(bits[1:0]);
      take_bits(3, bits);
      if (bits[2:0] == 3'd0) begin
        do_flush(idx, way, got);
      end else begin
        // Half the lookups reuse a stored tag to hit
        if (bits[0] && model[idx][way].valid) begin
          tag = model[idx][way].tag;
        end else begin
          fresh_tag(idx, tag);
        end
        do_lookup(idx, tag, bits[1], got);
      end
    end
    ready_gaps = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    lfsr_state = lfsr_seed;
    ready_gaps = 1'b0;
    rr_ptr     = 0;
    rst_n      = 1'b0;
    spm_lock   = '0;
    req        = '0;
    req_valid  = 1'b0;
    res_ready  = 1'b1;
    for (int s = 0; s < n_sets; s++) begin
      for (int w = 0; w < `TS_WAYS; w++) begin
        model[s][w] = '0;
      end
    end
    repeat (8) @(posedge clk);
    #(drive_dly);
    rst_n = 1'b1;

    test_miss_then_hit();
    test_dirty_hit_flush();
    test_round_robin();
    test_locked_ways();
    test_flush_clears();
    test_random_traffic();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: build.f
+incdir+hdl
hdl/tag_entry_pkg.sv
hdl/tag_access_pkg.sv
hdl/tag_way_ram.sv
hdl/tag_hit_detect.sv
hdl/victim_select.sv
hdl/tag_store_ctrl.sv
hdl/result_spill.sv
hdl/tag_store.sv
verif/tag_store_tb.sv

// File: run.sh
#!/bin/sh
# Compile the tag store testbench with Verilator, run it into a log and
# decide pass or fail from the log contents.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f build.f --top-module tag_store_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

./obj_dir/Vtag_store_tb > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "STATUS: PASS" "$log"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
